// File: uart_consts.svh
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// clk_uart cycles per serial bit
`define UART_BIT_CYCLES 16

// receiver waits this long after the start edge to reach mid-bit
`define UART_HALF_BIT   8

// word addresses on the 2-bit bus address
`define UART_ADR_TXDATA 2'd0
`define UART_ADR_RXDATA 2'd1
`define UART_ADR_STATUS 2'd2

`endif

// File: uart_pkg.sv
`default_nettype none

`include "uart_consts.svh"

package uart_pkg;

    // register select, decoded straight from wb_adr
    typedef enum logic [1:0] {
        REG_TXDATA = `UART_ADR_TXDATA,
        REG_RXDATA = `UART_ADR_RXDATA,
        REG_STATUS = `UART_ADR_STATUS
    } uart_reg_e;

    // shared by the transmit and receive shifters
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_START = 2'd1,
        ST_DATA  = 2'd2,
        ST_STOP  = 2'd3
    } serial_state_e;

endpackage

`default_nettype wire

// File: flag_sync.sv
`default_nettype none

module flag_sync (
    input  logic clk_src,
    input  logic clk_dst,
    input  logic rst_n,
    input  logic flag_src,
    output logic flag_dst
);

    logic       toggle_src;
    logic [2:0] sync_dst;

    // each source pulse flips the level once
    always_ff @(posedge clk_src or negedge rst_n) begin
        if (!rst_n) begin
            toggle_src <= 1'b0;
        end else if (flag_src) begin
            toggle_src <= ~toggle_src;
        end
    end

    always_ff @(posedge clk_dst or negedge rst_n) begin
        if (!rst_n) begin
            sync_dst <= 3'b000;
        end else begin
            sync_dst <= {sync_dst[1:0], toggle_src};
        end
    end

    // a level change after the synchronizer is one pulse
    assign flag_dst = sync_dst[2] ^ sync_dst[1];

endmodule

`default_nettype wire

// File: uart_tx.sv
`default_nettype none

`include "uart_consts.svh"

module uart_tx
    import uart_pkg::*;
(
    input  logic       clk_bus,
    input  logic       clk_uart,
    input  logic       rst_n,
    input  logic       tx_start,
    input  logic [7:0] tx_data,
    output logic       tx_idle,
    output logic       txd
);

    localparam int CNT_W = $clog2(`UART_BIT_CYCLES);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(`UART_BIT_CYCLES - 1);

    logic [7:0]       data_bus;
    logic             done_bus;
    logic             req_uart;
    logic             done_uart;
    logic [7:0]       data_sync [2];
    logic [9:0]       frame;
    logic [CNT_W-1:0] baud_cnt;
    logic [2:0]       bit_cnt;
    serial_state_e    state;

    flag_sync u_sync_req (
        .clk_src  (clk_bus),
        .clk_dst  (clk_uart),
        .rst_n    (rst_n),
        .flag_src (tx_start),
        .flag_dst (req_uart)
    );

    flag_sync u_sync_done (
        .clk_src  (clk_uart),
        .clk_dst  (clk_bus),
        .rst_n    (rst_n),
        .flag_src (done_uart),
        .flag_dst (done_bus)
    );

    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            tx_idle <= 1'b1;
        end else if (tx_start) begin
            tx_idle <= 1'b0;
        end else if (done_bus) begin
            tx_idle <= 1'b1;
        end
    end

    // byte stays put until the done pulse comes back
    always_ff @(posedge clk_bus) begin
        if (tx_start) begin
            data_bus <= tx_data;
        end
    end

    always_ff @(posedge clk_uart) begin
        data_sync[0] <= data_bus;
        data_sync[1] <= data_sync[0];
    end

    // frame shifts right and fills with ones, so an idle line reads high
    always_ff @(posedge clk_uart or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            frame     <= '1;
            baud_cnt  <= '0;
            bit_cnt   <= '0;
            done_uart <= 1'b0;
        end else begin
            done_uart <= 1'b0;
            if (state != ST_IDLE) begin
                baud_cnt <= (baud_cnt == '0) ? BIT_LAST : baud_cnt - 1'b1;
            end
            case (state)
                ST_IDLE: begin
                    if (req_uart) begin
                        frame    <= {1'b1, data_sync[1], 1'b0};
                        baud_cnt <= BIT_LAST;
                        state    <= ST_START;
                    end
                end
                ST_START: begin
                    if (baud_cnt == '0) begin
                        frame   <= {1'b1, frame[9:1]};
                        bit_cnt <= '0;
                        state   <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (baud_cnt == '0) begin
                        frame   <= {1'b1, frame[9:1]};
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= ST_STOP;
                        end
                    end
                end
                ST_STOP: begin
                    if (baud_cnt == '0) begin
                        done_uart <= 1'b1;
                        state     <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign txd = frame[0];

endmodule

`default_nettype wire

// File: uart_rx.sv
`default_nettype none

`include "uart_consts.svh"

module uart_rx
    import uart_pkg::*;
(
    input  logic       clk_bus,
    input  logic       clk_uart,
    input  logic       rst_n,
    input  logic       rxd,
    output logic       rx_strobe,
    output logic [7:0] rx_data,
    output logic       rx_frame_err_strobe
);

    localparam int CNT_W = $clog2(`UART_BIT_CYCLES);
    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(`UART_BIT_CYCLES - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(`UART_HALF_BIT - 1);

    // two synchronizer stages plus one for edge detection
    logic [2:0]       rxd_sync;
    logic             rxd_bit;
    logic             rxd_fall;
    logic [7:0]       shift;
    logic [CNT_W-1:0] baud_cnt;
    logic [2:0]       bit_cnt;
    logic             byte_uart;
    logic             err_uart;
    serial_state_e    state;

    flag_sync u_sync_byte (
        .clk_src  (clk_uart),
        .clk_dst  (clk_bus),
        .rst_n    (rst_n),
        .flag_src (byte_uart),
        .flag_dst (rx_strobe)
    );

    flag_sync u_sync_err (
        .clk_src  (clk_uart),
        .clk_dst  (clk_bus),
        .rst_n    (rst_n),
        .flag_src (err_uart),
        .flag_dst (rx_frame_err_strobe)
    );

    always_ff @(posedge clk_uart or negedge rst_n) begin
        if (!rst_n) begin
            rxd_sync <= 3'b111;
        end else begin
            rxd_sync <= {rxd_sync[1:0], rxd};
        end
    end

    assign rxd_bit  = rxd_sync[1];
    assign rxd_fall = rxd_sync[2] & ~rxd_sync[1];

    always_ff @(posedge clk_uart or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            baud_cnt  <= '0;
            bit_cnt   <= '0;
            byte_uart <= 1'b0;
            err_uart  <= 1'b0;
        end else begin
            byte_uart <= 1'b0;
            err_uart  <= 1'b0;
            if (state != ST_IDLE) begin
                baud_cnt <= (baud_cnt == '0) ? BIT_LAST : baud_cnt - 1'b1;
            end
            case (state)
                ST_IDLE: begin
                    if (rxd_fall) begin
                        baud_cnt <= HALF_LAST;
                        state    <= ST_START;
                    end
                end
                ST_START: begin
                    // a glitch shorter than half a bit is dropped here
                    if (baud_cnt == '0) begin
                        bit_cnt <= '0;
                        state   <= rxd_bit ? ST_IDLE : ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (baud_cnt == '0) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= ST_STOP;
                        end
                    end
                end
                ST_STOP: begin
                    if (baud_cnt == '0) begin
                        byte_uart <= rxd_bit;
                        err_uart  <= ~rxd_bit;
                        state     <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk_uart) begin
        if (state == ST_DATA && baud_cnt == '0) begin
            shift <= {rxd_bit, shift[7:1]};
        end
    end

    // held for a whole frame, long enough for the bus side to pick it up
    always_ff @(posedge clk_uart) begin
        if (state == ST_STOP && baud_cnt == '0 && rxd_bit) begin
            rx_data <= shift;
        end
    end

endmodule

`default_nettype wire

// File: uart_wb_regs.sv
`default_nettype none

module uart_wb_regs
    import uart_pkg::*;
(
    input  logic       clk_bus,
    input  logic       rst_n,
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  logic [1:0] wb_adr,
    input  logic [7:0] wb_wdata,
    output logic [7:0] wb_rdata,
    output logic       wb_ack,
    output logic       tx_start,
    output logic [7:0] tx_data,
    input  logic       tx_idle,
    input  logic       rx_strobe,
    input  logic [7:0] rx_data,
    input  logic       rx_frame_err_strobe
);

    uart_reg_e  reg_sel;
    logic       access;
    logic       rd_rx;
    logic       rd_status;
    logic       rx_valid;
    logic       rx_overrun;
    logic       rx_frame_err;
    logic [7:0] rx_byte;

    assign reg_sel   = uart_reg_e'(wb_adr);
    // true for exactly one cycle per bus cycle, the one that raises ack
    assign access    = wb_cyc && wb_stb && !wb_ack;
    assign rd_rx     = access && !wb_we && (reg_sel == REG_RXDATA);
    assign rd_status = access && !wb_we && (reg_sel == REG_STATUS);

    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack   <= 1'b0;
            tx_start <= 1'b0;
        end else begin
            wb_ack   <= access;
            tx_start <= access && wb_we && (reg_sel == REG_TXDATA) && tx_idle;
        end
    end

    always_ff @(posedge clk_bus) begin
        if (access && wb_we && (reg_sel == REG_TXDATA)) begin
            tx_data <= wb_wdata;
        end
    end

    always_ff @(posedge clk_bus) begin
        if (access) begin
            case (reg_sel)
                REG_RXDATA: wb_rdata <= wb_we ? 8'h00 : rx_byte;
                REG_STATUS: wb_rdata <= wb_we ? 8'h00 :
                                        {4'h0, rx_frame_err, rx_overrun, rx_valid, tx_idle};
                default:    wb_rdata <= 8'h00;
            endcase
        end
    end

    // newer byte always wins over an unread one
    always_ff @(posedge clk_bus) begin
        if (rx_strobe) begin
            rx_byte <= rx_data;
        end
    end

    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            rx_valid     <= 1'b0;
            rx_overrun   <= 1'b0;
            rx_frame_err <= 1'b0;
        end else begin
            if (rx_strobe) begin
                rx_valid <= 1'b1;
                if (rx_valid && !rd_rx) begin
                    rx_overrun <= 1'b1;
                end else if (rd_rx) begin
                    rx_overrun <= 1'b0;
                end
            end else if (rd_rx) begin
                rx_valid   <= 1'b0;
                rx_overrun <= 1'b0;
            end

            if (rx_frame_err_strobe) begin
                rx_frame_err <= 1'b1;
            end else if (rd_status) begin
                rx_frame_err <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: uart_top.sv
`default_nettype none

module uart_top (
    input  logic       clk_bus,
    input  logic       clk_uart,
    input  logic       rst_n,
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  logic [1:0] wb_adr,
    input  logic [7:0] wb_wdata,
    output logic [7:0] wb_rdata,
    output logic       wb_ack,
    output logic       txd,
    input  logic       rxd
);

    logic       tx_start;
    logic [7:0] tx_data;
    logic       tx_idle;
    logic       rx_strobe;
    logic [7:0] rx_data;
    logic       rx_frame_err_strobe;

    uart_wb_regs u_regs (
        .clk_bus             (clk_bus),
        .rst_n               (rst_n),
        .wb_cyc              (wb_cyc),
        .wb_stb              (wb_stb),
        .wb_we               (wb_we),
        .wb_adr              (wb_adr),
        .wb_wdata            (wb_wdata),
        .wb_rdata            (wb_rdata),
        .wb_ack              (wb_ack),
        .tx_start            (tx_start),
        .tx_data             (tx_data),
        .tx_idle             (tx_idle),
        .rx_strobe           (rx_strobe),
        .rx_data             (rx_data),
        .rx_frame_err_strobe (rx_frame_err_strobe)
    );

    uart_tx u_tx (
        .clk_bus  (clk_bus),
        .clk_uart (clk_uart),
        .rst_n    (rst_n),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx_idle  (tx_idle),
        .txd      (txd)
    );

    uart_rx u_rx (
        .clk_bus             (clk_bus),
        .clk_uart            (clk_uart),
        .rst_n               (rst_n),
        .rxd                 (rxd),
        .rx_strobe           (rx_strobe),
        .rx_data             (rx_data),
        .rx_frame_err_strobe (rx_frame_err_strobe)
    );

endmodule

`default_nettype wire

// File: tb_uart_top.sv
`default_nettype none

`include "uart_consts.svh"

module tb_uart_top
    import uart_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int BUS_HALF       = 4;
    localparam int UART_HALF      = 3;
    // one serial bit of 16 x 6 ns lasts exactly 12 bus cycles of 8 ns
    localparam int BUS_PER_BIT    = `UART_BIT_CYCLES * 2 * UART_HALF / (2 * BUS_HALF);
    localparam int N_LOOP         = 3;
    localparam int N_FRAMES       = 8;
    localparam int TIMEOUT_CYCLES = 2 * N_FRAMES * 10 * `UART_BIT_CYCLES;

    logic       clk_bus  = 1'b0;
    logic       clk_uart = 1'b0;
    logic       rst_n;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    logic [1:0] wb_adr;
    logic [7:0] wb_wdata;
    logic [7:0] wb_rdata;
    logic       wb_ack;
    logic       txd;
    logic       rxd;
    logic       rxd_drv;
    logic       loop_en;

    int         err_count     = 0;
    int         check_count   = 0;
    int         mon_errors    = 0;
    int         mon_checks    = 0;
    int         frames_seen   = 0;
    int         n_pushed      = 0;
    int         test_num      = 0;
    int         tests_failed  = 0;
    int         errs_at_start = 0;
    int         cycle_cnt     = 0;
    logic [7:0] exp_bytes [16];
    logic       m_valid;
    logic       m_overrun;
    logic       m_ferr;

    always #BUS_HALF clk_bus = ~clk_bus;
    always #UART_HALF clk_uart = ~clk_uart;

    // loopback unless a hand-built frame is being driven
    assign rxd = loop_en ? txd : rxd_drv;

    uart_top u_dut (
        .clk_bus  (clk_bus),
        .clk_uart (clk_uart),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_wdata (wb_wdata),
        .wb_rdata (wb_rdata),
        .wb_ack   (wb_ack),
        .txd      (txd),
        .rxd      (rxd)
    );

    // bit 0 leaves the pin first
    function automatic logic [9:0] frame_bits(input logic [7:0] data);
        return {1'b1, data, 1'b0};
    endfunction

    function automatic logic [7:0] expected_status(input logic idle, input logic valid,
                                                   input logic overrun, input logic ferr);
        return {4'h0, ferr, overrun, valid, idle};
    endfunction

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        check_count++;
        assert (got === exp) else begin
            err_count++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic bus_write(input uart_reg_e adr, input logic [7:0] data);
        @(negedge clk_bus);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_wdata = data;
        @(negedge clk_bus);
        // ack follows stb by one bus cycle
        check_value("wb_ack", {7'h00, wb_ack}, 8'h01);
        while (!wb_ack) @(negedge clk_bus);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic bus_read(input uart_reg_e adr, output logic [7:0] data);
        @(negedge clk_bus);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        @(negedge clk_bus);
        check_value("wb_ack", {7'h00, wb_ack}, 8'h01);
        while (!wb_ack) @(negedge clk_bus);
        data   = wb_rdata;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic expect_frame(input logic [7:0] data);
        exp_bytes[n_pushed] = data;
        n_pushed++;
    endtask

    task automatic wait_tx_idle();
        logic [7:0] st;
        st = 8'h00;
        while (!st[0]) bus_read(REG_STATUS, st);
    endtask

    // polls STATUS until the flags match the model
    task automatic wait_status(input logic [7:0] exp);
        logic [7:0] st;
        st = ~exp;
        while (st !== exp) bus_read(REG_STATUS, st);
    endtask

    task automatic complete_loopback();
        wait_tx_idle();
        m_overrun = m_overrun | m_valid;
        m_valid   = 1'b1;
        wait_status(expected_status(1'b1, m_valid, m_overrun, m_ferr));
    endtask

    task automatic loop_byte(input logic [7:0] data);
        expect_frame(data);
        bus_write(REG_TXDATA, data);
        complete_loopback();
    endtask

    task automatic read_rx_check(input logic [7:0] exp);
        logic [7:0] rd;
        bus_read(REG_RXDATA, rd);
        check_value("rx_data", rd, exp);
        m_valid   = 1'b0;
        m_overrun = 1'b0;
    endtask

    task automatic send_bad_frame(input logic [7:0] data);
        logic [9:0] bits;
        bits = {1'b0, data, 1'b0};
        @(negedge clk_bus);
        for (int i = 0; i < 10; i++) begin
            rxd_drv = bits[i];
            repeat (BUS_PER_BIT) @(negedge clk_bus);
        end
        rxd_drv = 1'b1;
    endtask

    task automatic start_test();
        test_num++;
        errs_at_start = err_count + mon_errors;
    endtask

    task automatic finish_test(input string name);
        int n;
        n = err_count + mon_errors - errs_at_start;
        if (n == 0) begin
            $display("test %0d %s: pass", test_num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: fail, %0d errors", test_num, name, n);
        end
    endtask

    // compares each txd frame at mid-bit with the next accepted byte
    always begin : txd_monitor
        logic [9:0] exp_bits;
        @(negedge txd);
        if (frames_seen >= n_pushed) begin
            mon_errors++;
            $display("a frame started on txd without an accepted TXDATA write");
            repeat (10 * `UART_BIT_CYCLES) @(negedge clk_uart);
        end else begin
            exp_bits = frame_bits(exp_bytes[frames_seen]);
            repeat (`UART_HALF_BIT) @(negedge clk_uart);
            for (int i = 0; i < 10; i++) begin
                mon_checks++;
                assert (txd === exp_bits[i]) else begin
                    mon_errors++;
                    $display("[ERROR] txd bit %0d: got 0x%h, expected 0x%h",
                             i, txd, exp_bits[i]);
                end
                if (i < 9) repeat (`UART_BIT_CYCLES) @(negedge clk_uart);
            end
        end
        frames_seen++;
    end

    always @(posedge clk_uart) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d clk_uart cycles", TIMEOUT_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin : main_seq
        logic [7:0] st;
        logic [7:0] b1;
        logic [7:0] b2;
        void'($urandom(19));
        rst_n     = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = 2'd0;
        wb_wdata  = 8'h00;
        rxd_drv   = 1'b1;
        loop_en   = 1'b1;
        m_valid   = 1'b0;
        m_overrun = 1'b0;
        m_ferr    = 1'b0;
        repeat (10) @(negedge clk_bus);
        rst_n = 1'b1;

        start_test();
        bus_read(REG_STATUS, st);
        check_value("status", st, expected_status(1'b1, m_valid, m_overrun, m_ferr));
        check_value("txd", {7'h00, txd}, 8'h01);
        finish_test("reset state");

        start_test();
        b1 = 8'($urandom);
        expect_frame(b1);
        bus_write(REG_TXDATA, b1);
        bus_read(REG_STATUS, st);
        check_value("status.tx_idle", {7'h00, st[0]}, 8'h00);
        complete_loopback();
        check_value("frames on txd", 8'(frames_seen), 8'(n_pushed));
        read_rx_check(b1);
        finish_test("single tx frame");

        start_test();
        for (int k = 0; k < N_LOOP; k++) begin
            b1 = 8'($urandom);
            loop_byte(b1);
            read_rx_check(b1);
            bus_read(REG_STATUS, st);
            check_value("status", st, expected_status(1'b1, m_valid, m_overrun, m_ferr));
        end
        finish_test("loopback bytes");

        start_test();
        b1 = 8'($urandom);
        b2 = b1 ^ 8'h81;
        expect_frame(b1);
        bus_write(REG_TXDATA, b1);
        // tx is busy by now, so this byte must be dropped
        bus_write(REG_TXDATA, b2);
        complete_loopback();
        check_value("frames on txd", 8'(frames_seen), 8'(n_pushed));
        read_rx_check(b1);
        finish_test("write while busy");

        start_test();
        b1 = 8'($urandom);
        b2 = 8'($urandom);
        loop_byte(b1);
        loop_byte(b2);
        read_rx_check(b2);
        bus_read(REG_STATUS, st);
        check_value("status", st, expected_status(1'b1, m_valid, m_overrun, m_ferr));
        finish_test("rx overrun");

        start_test();
        loop_en = 1'b0;
        b1 = 8'($urandom);
        send_bad_frame(b1);
        m_ferr = 1'b1;
        wait_status(expected_status(1'b1, m_valid, m_overrun, m_ferr));
        // the status read that showed the flag also cleared it
        m_ferr = 1'b0;
        bus_read(REG_STATUS, st);
        check_value("status", st, expected_status(1'b1, m_valid, m_overrun, m_ferr));
        loop_en = 1'b1;
        finish_test("frame error");

        $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d", test_num,
                 tests_failed, check_count + mon_checks, err_count + mon_errors);
        if (err_count + mon_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: uart_top.f
+incdir+.
uart_pkg.sv
flag_sync.sv
uart_tx.sv
uart_rx.sv
uart_wb_regs.sv
uart_top.sv
tb_uart_top.sv

// File: Makefile
TOP := tb_uart_top

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f uart_top.f --top-module $(TOP) -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
